//--- project.f
hw/ciPkg.sv
hw/resetStretcher.sv
hw/ciDispatcher.sv
hw/microDelay.sv
hw/busErrorCounter.sv
hw/strobeControl.sv
hw/ciSubsystem.sv
bench/ciSubsystem_asserts.sv
bench/ciSubsystemTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= ciSubsystemTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= sim passed
ERROR_LIMIT ?= 100
COMMON_FLAGS ?= --timing --assert --timescale 1ns/10ps
VFLAGS ?= --binary $(COMMON_FLAGS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "PASS" || (echo "FAIL" && exit 1)

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/ciSubsystemTb.sv
`timescale 1ns/10ps
`default_nettype none

module ciSubsystemTb;
  import ciPkg::*;

  // Whole run needs a few hundred cycles
  localparam int TIMEOUT_CYCLES = 3000;
  localparam int DONE_LIMIT = 200;

  logic s_systemClock;
  logic s_pllLocked;
  logic ciStart;
  logic busError;
  logic camVsync;
  logic ciDone;
  logic strobe;
  ciNumber_t ciN;
  ciWord_t ciDataA;
  ciWord_t ciDataB;
  ciWord_t ciResult;
  ciWord_t operand;
  integer seed;
  int cycleCount = 0;
  int missedDone = 0;
  int lastFailCount = 0;
  int passedTests = 0;
  int failedTests = 0;
  int pulses;

  ciSubsystem #(
    .CLOCKS_PER_MICROSECOND(3)
  ) dut (.*);

  initial begin
    s_systemClock = 1'b0;
    forever #10 s_systemClock = ~s_systemClock;
  end

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles", cycleCount);
      $display("sim failed");
      $finish;
    end
  end

  task automatic nextCycle();
    @(posedge s_systemClock);
    #2;
  endtask

  // Called 2 ns after an edge, returns 2 ns after the edge that ends done
  task automatic issueInstruction(input ciNumber_t number, input ciWord_t a, input ciWord_t b);
    int waited;
    waited = 0;
    ciStart = 1'b1;
    ciN = number;
    ciDataA = a;
    ciDataB = b;
    @(negedge s_systemClock);
    while (!ciDone && waited < DONE_LIMIT) begin
      nextCycle();
      ciStart = 1'b0;
      waited++;
      @(negedge s_systemClock);
    end
    if (!ciDone) begin
      $display("instruction %0d issued before %0t never signalled done", number, $time);
      missedDone++;
    end
    nextCycle();
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
  endtask

  task automatic pulseBusError();
    busError = 1'b1;
    nextCycle();
    busError = 1'b0;
    nextCycle();
  endtask

  task automatic raiseVsync(input int highCycles);
    camVsync = 1'b1;
    repeat (highCycles) nextCycle();
    camVsync = 1'b0;
  endtask

  task automatic reportTest(input string name);
    int newFailures;
    newFailures = dut.checks.failCount - lastFailCount + missedDone;
    lastFailCount = dut.checks.failCount;
    missedDone = 0;
    if (newFailures == 0) begin
      passedTests++;
      $display("test %s: ok", name);
    end else begin
      failedTests++;
      $display("test %s: %0d errors", name, newFailures);
    end
  endtask

  initial begin
    seed = 74495;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    busError = 1'b0;
    camVsync = 1'b0;
    repeat (4) @(posedge s_systemClock);
    #2 s_pllLocked = 1'b1;
    // A start while the internal reset is still held gets no answer
    ciStart = 1'b1;
    ciN = CI_ID_SWAP_BYTE;
    ciDataA = 32'h0102_0304;
    nextCycle();
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    repeat (19) nextCycle();
    reportTest("reset");

    for (int i = 0; i < 20; i++) begin
      operand = $random(seed);
      issueInstruction(CI_ID_SWAP_BYTE, operand, 32'd0);
      issueInstruction(CI_ID_SWAP_BYTE, operand, 32'd1);
    end
    issueInstruction(8'd99, $random(seed), $random(seed));
    reportTest("byte swap");

    issueInstruction(CI_ID_DELAY, 32'd0, '0);
    issueInstruction(CI_ID_DELAY, 32'd1, '0);
    issueInstruction(CI_ID_DELAY, 32'd5, '0);
    reportTest("delay");

    pulses = 3 + int'($unsigned($random(seed)) % 8);
    repeat (pulses) pulseBusError();
    issueInstruction(CI_ID_BUS_ERROR, '0, 32'd0);
    issueInstruction(CI_ID_BUS_ERROR, '0, 32'd1);
    issueInstruction(CI_ID_BUS_ERROR, '0, 32'd0);
    repeat (2) pulseBusError();
    // Clear with a pulse landing in the done cycle
    ciStart = 1'b1;
    ciN = CI_ID_BUS_ERROR;
    ciDataB = 32'd1;
    nextCycle();
    ciStart = 1'b0;
    ciDataB = '0;
    busError = 1'b1;
    nextCycle();
    busError = 1'b0;
    issueInstruction(CI_ID_BUS_ERROR, '0, 32'd0);
    reportTest("bus errors");

    issueInstruction(CI_ID_STROBE, ciWord_t'(STROBE_OP_SET_DELAY), 32'd4);
    issueInstruction(CI_ID_STROBE, ciWord_t'(STROBE_OP_SET_LENGTH), 32'd6);
    issueInstruction(CI_ID_STROBE, ciWord_t'(STROBE_OP_READ), '0);
    raiseVsync(3);
    repeat (4) nextCycle();
    // Second edge falls inside the window
    raiseVsync(3);
    repeat (20) nextCycle();
    issueInstruction(CI_ID_STROBE, ciWord_t'(STROBE_OP_SET_LENGTH), 32'd0);
    raiseVsync(3);
    repeat (20) nextCycle();
    reportTest("strobe");

    $display("tests ok: %0d, tests with errors: %0d", passedTests, failedTests);
    if (failedTests == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/ciSubsystem_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module ciSubsystem_asserts #(
  parameter int CLOCKS_PER_MICROSECOND = 75,
  parameter int RESET_CYCLES = 16
) (
  input logic             s_systemClock,
  input logic             s_pllLocked,
  input logic             ciStart,
  input ciPkg::ciNumber_t ciN,
  input ciPkg::ciWord_t   ciDataA,
  input ciPkg::ciWord_t   ciDataB,
  input logic             busError,
  input logic             camVsync,
  input logic             ciDone,
  input ciPkg::ciWord_t   ciResult,
  input logic             strobe
);
  import ciPkg::*;

  int failCount = 0;
  int lockedCycles;
  int delayElapsed;
  int delayTarget;
  int windowClock;
  logic inReset;
  logic knownNumber;
  logic delayPending;
  logic replyPending;
  logic clearNext;
  logic vsyncPrev;
  logic expectStrobe;
  ciWord_t replyExpected;
  ciWord_t errorModel;
  strobeCount_t delaySetting, lengthSetting, windowDelay, windowLength;

  // Byte i of the result comes from byte 3-i, or from its half-word neighbour
  function automatic ciWord_t swapRule(input ciWord_t word, input logic halfWords);
    ciWord_t swapped;
    for (int i = 0; i < 4; i++) begin
      swapped[8*i +: 8] = word[8*(halfWords ? (i ^ 1) : (3 - i)) +: 8];
    end
    return swapped;
  endfunction

  task automatic flagFailure(input string what);
    failCount++;
    $error("ERROR at %0t: %s", $time, what);
  endtask

  assign inReset = lockedCycles < RESET_CYCLES;
  assign knownNumber = ciN inside {CI_ID_SWAP_BYTE, CI_ID_DELAY, CI_ID_BUS_ERROR, CI_ID_STROBE};
  assign expectStrobe = (windowClock >= int'(windowDelay) + 3) &&
      (windowClock < int'(windowDelay) + 3 + int'(windowLength));

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockedCycles <= 0;
    end else if (inReset) begin
      lockedCycles <= lockedCycles + 1;
    end
  end

  // Reference model of the expected answers
  always_ff @(posedge s_systemClock) begin
    if (inReset) begin
      delayPending <= 1'b0;
      replyPending <= 1'b0;
      clearNext <= 1'b0;
      errorModel <= '0;
      delaySetting <= '0;
      lengthSetting <= '0;
      windowClock <= 0;
      vsyncPrev <= 1'b0;
    end else begin
      vsyncPrev <= camVsync;
      replyPending <= ciStart && (ciN == CI_ID_BUS_ERROR || ciN == CI_ID_STROBE);
      clearNext <= ciStart && (ciN == CI_ID_BUS_ERROR) && ciDataB[0];
      if (clearNext) begin
        errorModel <= ciWord_t'(busError);
      end else if (busError) begin
        errorModel <= errorModel + 32'd1;
      end
      if (ciStart && ciN == CI_ID_BUS_ERROR) begin
        replyExpected <= errorModel;
      end
      if (ciStart && ciN == CI_ID_STROBE) begin
        replyExpected <= (ciDataA[1:0] == STROBE_OP_READ) ? {lengthSetting, delaySetting} : '0;
        if (ciDataA[1:0] == STROBE_OP_SET_DELAY) delaySetting <= ciDataB[15:0];
        if (ciDataA[1:0] == STROBE_OP_SET_LENGTH) lengthSetting <= ciDataB[15:0];
      end
      if (ciStart && ciN == CI_ID_DELAY) begin
        delayPending <= 1'b1;
        delayElapsed <= 1;
        delayTarget <= int'(ciDataA) * CLOCKS_PER_MICROSECOND + 1;
      end else if (delayPending) begin
        delayElapsed <= delayElapsed + 1;
        if (ciDone) delayPending <= 1'b0;
      end
      // Window counts samples since the accepted vsync edge
      if (windowClock != 0) begin
        windowClock <= (windowClock >= int'(windowDelay) + 2 + int'(windowLength)) ?
            0 : windowClock + 1;
      end else if (camVsync && !vsyncPrev && lengthSetting != '0) begin
        windowClock <= 1;
        windowDelay <= delaySetting;
        windowLength <= lengthSetting;
      end
    end
  end

  assert property (@(posedge s_systemClock) inReset |-> !ciDone && !strobe)
    else flagFailure("done or strobe active during reset");
  assert property (@(posedge s_systemClock) !ciDone |-> ciResult == '0)
    else flagFailure("result not zero outside done");
  assert property (@(posedge s_systemClock) disable iff (inReset)
      ciStart && ciN == CI_ID_SWAP_BYTE |-> ciDone && ciResult == swapRule(ciDataA, ciDataB[0]))
    else flagFailure("byte swap answer wrong");
  assert property (@(posedge s_systemClock) disable iff (inReset)
      ciStart && !knownNumber |-> ciDone && ciResult == '0)
    else flagFailure("unknown number not answered with zero");
  assert property (@(posedge s_systemClock) disable iff (inReset)
      delayPending |-> ciDone == (delayElapsed == delayTarget) && ciResult == '0)
    else flagFailure("delay done at the wrong cycle or result not zero");
  assert property (@(posedge s_systemClock) disable iff (inReset)
      replyPending |-> ciDone && ciResult == replyExpected)
    else flagFailure("bus error or strobe answer wrong");
  assert property (@(posedge s_systemClock) disable iff (inReset) strobe == expectStrobe)
    else flagFailure("strobe output wrong");

endmodule

bind ciSubsystem ciSubsystem_asserts #(
  .CLOCKS_PER_MICROSECOND(CLOCKS_PER_MICROSECOND),
  .RESET_CYCLES(RESET_CYCLES)
) checks (.*);

`default_nettype wire

//--- hw/ciSubsystem.sv
`timescale 1ns/10ps
`default_nettype none

module ciSubsystem #(
  parameter int CLOCKS_PER_MICROSECOND = 75,
  parameter int RESET_CYCLES = 16
) (
  input  logic             s_systemClock,
  input  logic             s_pllLocked,
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  input  logic             busError,
  input  logic             camVsync,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult,
  output logic             strobe
);
  import ciPkg::*;

  logic s_reset;
  logic s_delayStart, s_errorStart, s_strobeStart;
  logic s_delayDone, s_errorDone, s_strobeDone;
  ciWord_t s_delayResult, s_errorResult, s_strobeResult;

  resetStretcher #(
    .RESET_CYCLES(RESET_CYCLES)
  ) resetGen (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .reset(s_reset)
  );

  ciDispatcher dispatcher (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .delayStart(s_delayStart),
    .errorStart(s_errorStart),
    .strobeStart(s_strobeStart),
    .delayDone(s_delayDone),
    .errorDone(s_errorDone),
    .strobeDone(s_strobeDone),
    .delayResult(s_delayResult),
    .errorResult(s_errorResult),
    .strobeResult(s_strobeResult),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  microDelay #(
    .CLOCKS_PER_MICROSECOND(CLOCKS_PER_MICROSECOND)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .start(s_delayStart),
    .microseconds(ciDataA),
    .done(s_delayDone),
    .result(s_delayResult)
  );

  busErrorCounter errorCounter (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .busError(busError),
    .start(s_errorStart),
    .clearRequest(ciDataB[0]),
    .done(s_errorDone),
    .result(s_errorResult)
  );

  // Vsync is sampled in the system clock domain
  strobeControl strobeCtrl (
    .s_systemClock(s_systemClock),
    .reset(s_reset),
    .trigger(camVsync),
    .start(s_strobeStart),
    .operation(ciDataA),
    .value(ciDataB),
    .done(s_strobeDone),
    .result(s_strobeResult),
    .strobe(strobe)
  );

endmodule

`default_nettype wire

//--- hw/strobeControl.sv
`timescale 1ns/10ps
`default_nettype none

module strobeControl (
  input  logic           s_systemClock,
  input  logic           reset,
  input  logic           trigger,
  input  logic           start,
  input  ciPkg::ciWord_t operation,
  input  ciPkg::ciWord_t value,
  output logic           done,
  output ciPkg::ciWord_t result,
  output logic           strobe
);
  import ciPkg::*;

  strobeState_t state;
  logic [2:0] triggerSync;
  logic triggerRise;
  strobeCount_t strobeDelay;
  strobeCount_t strobeLength;
  strobeCount_t phaseCount;
  ciWord_t readBack;

  // Two sync flops, the third only remembers the previous level
  assign triggerRise = triggerSync[1] && !triggerSync[2];
  assign strobe = state == STROBE_ACTIVE;
  assign result = readBack;

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      state <= STROBE_IDLE;
      triggerSync <= '0;
      strobeDelay <= '0;
      strobeLength <= '0;
      phaseCount <= '0;
      done <= 1'b0;
    end else begin
      triggerSync <= {triggerSync[1:0], trigger};
      done <= start;
      if (start) begin
        case (operation[1:0])
          STROBE_OP_SET_DELAY: strobeDelay <= value[15:0];
          STROBE_OP_SET_LENGTH: strobeLength <= value[15:0];
          default: strobeDelay <= strobeDelay;
        endcase
      end
      case (state)
        STROBE_IDLE: begin
          // A zero length keeps the strobe off
          if (triggerRise && (strobeLength != '0)) begin
            if (strobeDelay == '0) begin
              state <= STROBE_ACTIVE;
              phaseCount <= strobeLength;
            end else begin
              state <= STROBE_WAITING;
              phaseCount <= strobeDelay;
            end
          end
        end
        STROBE_WAITING: begin
          if (phaseCount <= 16'd1) begin
            state <= (strobeLength == '0) ? STROBE_IDLE : STROBE_ACTIVE;
            phaseCount <= strobeLength;
          end else begin
            phaseCount <= phaseCount - 16'd1;
          end
        end
        STROBE_ACTIVE: begin
          if (phaseCount <= 16'd1) begin
            state <= STROBE_IDLE;
          end else begin
            phaseCount <= phaseCount - 16'd1;
          end
        end
        default: state <= STROBE_IDLE;
      endcase
    end
  end

  always_ff @(posedge s_systemClock) begin
    if (start) begin
      readBack <= (operation[1:0] == STROBE_OP_READ) ? {strobeLength, strobeDelay} : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/busErrorCounter.sv
`timescale 1ns/10ps
`default_nettype none

module busErrorCounter (
  input  logic           s_systemClock,
  input  logic           reset,
  input  logic           busError,
  input  logic           start,
  input  logic           clearRequest,
  output logic           done,
  output ciPkg::ciWord_t result
);
  import ciPkg::*;

  ciWord_t errorCount;
  ciWord_t countSnapshot;
  logic clearPending;

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      errorCount <= '0;
      clearPending <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= start;
      clearPending <= start && clearRequest;
      // Restart in the done cycle, keeping a pulse that lands there
      if (clearPending) begin
        errorCount <= ciWord_t'(busError);
      end else if (busError) begin
        errorCount <= errorCount + 32'd1;
      end
    end
  end

  // Count as it was before the start cycle
  always_ff @(posedge s_systemClock) begin
    if (start) begin
      countSnapshot <= errorCount;
    end
  end

  assign result = countSnapshot;

endmodule

`default_nettype wire

//--- hw/microDelay.sv
`timescale 1ns/10ps
`default_nettype none

module microDelay #(
  parameter int CLOCKS_PER_MICROSECOND = 75
) (
  input  logic           s_systemClock,
  input  logic           reset,
  input  logic           start,
  input  ciPkg::ciWord_t microseconds,
  output logic           done,
  output ciPkg::ciWord_t result
);
  import ciPkg::*;

  localparam int PRESCALE_WIDTH = $clog2(CLOCKS_PER_MICROSECOND + 1);
  localparam logic [PRESCALE_WIDTH-1:0] PRESCALE_LAST =
      PRESCALE_WIDTH'(CLOCKS_PER_MICROSECOND - 1);

  delayState_t state;
  logic [PRESCALE_WIDTH-1:0] prescale;
  ciWord_t remaining;
  logic microTick;

  assign microTick = prescale == PRESCALE_LAST;
  assign result = '0;

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      state <= DELAY_IDLE;
      prescale <= '0;
      remaining <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        DELAY_IDLE: begin
          prescale <= '0;
          if (start) begin
            // Zero microseconds answers on the next cycle
            if (microseconds == '0) begin
              done <= 1'b1;
            end else begin
              remaining <= microseconds;
              state <= DELAY_COUNTING;
            end
          end
        end
        DELAY_COUNTING: begin
          if (microTick) begin
            prescale <= '0;
            remaining <= remaining - 32'd1;
            if (remaining == 32'd1) begin
              done <= 1'b1;
              state <= DELAY_IDLE;
            end
          end else begin
            prescale <= prescale + 1'b1;
          end
        end
        default: state <= DELAY_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/ciDispatcher.sv
`timescale 1ns/10ps
`default_nettype none

module ciDispatcher (
  input  logic             s_systemClock,
  input  logic             reset,
  input  logic             ciStart,
  input  ciPkg::ciNumber_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             delayStart,
  output logic             errorStart,
  output logic             strobeStart,
  input  logic             delayDone,
  input  logic             errorDone,
  input  logic             strobeDone,
  input  ciPkg::ciWord_t   delayResult,
  input  ciPkg::ciWord_t   errorResult,
  input  ciPkg::ciWord_t   strobeResult,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult
);
  import ciPkg::*;

  dispatchState_t state;
  ciNumber_t pendingId;
  logic accept;
  logic isSwap;
  logic isUnit;
  logic unitDone;
  ciWord_t unitResult;
  ciWord_t swapResult;

  // Nothing is answered while the internal reset is held
  assign accept = ciStart && !reset && (state == DISPATCH_IDLE);
  assign isSwap = ciN == CI_ID_SWAP_BYTE;
  assign isUnit = (ciN == CI_ID_DELAY) || (ciN == CI_ID_BUS_ERROR) || (ciN == CI_ID_STROBE);

  assign delayStart = accept && (ciN == CI_ID_DELAY);
  assign errorStart = accept && (ciN == CI_ID_BUS_ERROR);
  assign strobeStart = accept && (ciN == CI_ID_STROBE);

  // Bit 0 of B picks full reversal or half-word swap
  assign swapResult = ciDataB[0] ?
      {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]} :
      {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // Only the pending unit may answer
  always_comb begin
    unitDone = 1'b0;
    unitResult = '0;
    if (state == DISPATCH_WAITING) begin
      case (pendingId)
        CI_ID_DELAY: begin
          unitDone = delayDone;
          unitResult = delayResult;
        end
        CI_ID_BUS_ERROR: begin
          unitDone = errorDone;
          unitResult = errorResult;
        end
        CI_ID_STROBE: begin
          unitDone = strobeDone;
          unitResult = strobeResult;
        end
        default: unitDone = 1'b0;
      endcase
    end
  end

  // Swap and unknown numbers finish in the start cycle
  assign ciDone = (accept && !isUnit) || unitDone;
  assign ciResult = (accept && isSwap) ? swapResult : (unitDone ? unitResult : '0);

  always_ff @(posedge s_systemClock or posedge reset) begin
    if (reset) begin
      state <= DISPATCH_IDLE;
      pendingId <= '0;
    end else if (accept && isUnit) begin
      state <= DISPATCH_WAITING;
      pendingId <= ciN;
    end else if (unitDone) begin
      state <= DISPATCH_IDLE;
    end
  end

endmodule

`default_nettype wire

//--- hw/resetStretcher.sv
`timescale 1ns/10ps
`default_nettype none

module resetStretcher #(
  parameter int RESET_CYCLES = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic reset
);

  localparam int COUNT_WIDTH = $clog2(RESET_CYCLES + 1);
  localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(RESET_CYCLES);

  logic [COUNT_WIDTH-1:0] lockCount;

  // Saturates once the PLL has been stable long enough
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
    end else if (lockCount != COUNT_LAST) begin
      lockCount <= lockCount + 1'b1;
    end
  end

  assign reset = lockCount != COUNT_LAST;

endmodule

`default_nettype wire

//--- hw/ciPkg.sv
`default_nettype none

package ciPkg;

  // Operand and result word of the custom-instruction port
  typedef logic [31:0] ciWord_t;
  typedef logic [7:0] ciNumber_t;

  // Strobe delay or length in system clock cycles
  typedef logic [15:0] strobeCount_t;

  localparam ciNumber_t CI_ID_SWAP_BYTE = 8'd1;
  localparam ciNumber_t CI_ID_DELAY = 8'd6;
  localparam ciNumber_t CI_ID_BUS_ERROR = 8'd10;
  localparam ciNumber_t CI_ID_STROBE = 8'd14;

  // Strobe sub-operations, carried in ciDataA[1:0]
  localparam logic [1:0] STROBE_OP_READ = 2'd0;
  localparam logic [1:0] STROBE_OP_SET_DELAY = 2'd1;
  localparam logic [1:0] STROBE_OP_SET_LENGTH = 2'd2;

  typedef enum logic {
    DISPATCH_IDLE,
    DISPATCH_WAITING
  } dispatchState_t;

  typedef enum logic {
    DELAY_IDLE,
    DELAY_COUNTING
  } delayState_t;

  typedef enum logic [1:0] {
    STROBE_IDLE,
    STROBE_WAITING,
    STROBE_ACTIVE
  } strobeState_t;

endpackage

`default_nettype wire
